// ==== tb.f ====
source/exe_pkg.sv
source/dispatch_decode.sv
source/res_station.sv
source/sc_alu.sv
source/mc_unit.sv
source/result_arbiter.sv
source/exe_core.sv
verif/exe_core_tb.sv

// ==== verif/exe_core_tb.sv ====
// exe_core testbench with instruction table, program-order reference model and writeback monitor
`timescale 1ns/1ns
module exe_core_tb;

  localparam int RS_ENTRIES = 8;
  localparam int MAX_ROWS   = 128;

  logic                   clk;
  logic                   reset;
  logic                   dispatch_valid;
  exe_pkg::dispatch_req_t dispatch_req;
  logic                   dispatch_stall;
  logic [6:0]             dispatch_robid;
  logic                   wb_valid;
  exe_pkg::wb_t           wb;

  exe_pkg::dispatch_req_t table_rows [MAX_ROWS];
  logic [31:0]            exp_result [MAX_ROWS];
  logic [4:0]             exp_rd [MAX_ROWS];
  logic                   wb_seen [MAX_ROWS];
  logic [31:0]            model_regs [32];
  integer                 seed;
  int                     num_rows = 0;
  int                     accepted_count = 0;
  int                     wb_count = 0;
  int                     reset_edges = 0;
  int                     mismatches = 0;
  int                     duplicates = 0;
  int                     missing = 0;
  int                     other_errors = 0;
  logic                   stall_seen = 1'b0;
  logic                   table_ready = 1'b0;

  exe_core #(.RS_ENTRIES(RS_ENTRIES)) u_exe_core (
    .clk(clk), .reset(reset), .dispatch_valid(dispatch_valid), .dispatch_req(dispatch_req),
    .dispatch_stall(dispatch_stall), .dispatch_robid(dispatch_robid),
    .wb_valid(wb_valid), .wb(wb)
  );

  always #50 clk = ~clk;

  task automatic add_row(input exe_pkg::opcode_e op, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [31:0] imm, input logic use_imm);
    exe_pkg::dispatch_req_t row;
    row.op      = op;
    row.rd      = rd;
    row.rs1     = rs1;
    row.rs2     = rs2;
    row.imm     = imm;
    row.use_imm = use_imm;
    table_rows[num_rows] = row;
    num_rows++;
  endtask

  // Result of one instruction as the ISA defines it
  function automatic logic [31:0] expected_value(input exe_pkg::opcode_e op,
                                                 input logic [31:0] a, input logic [31:0] b);
    logic [63:0] product;
    logic [31:0] value;
    product = {32'b0, a} * {32'b0, b};
    case (op)
      exe_pkg::OP_ADD:   value = a + b;
      exe_pkg::OP_SUB:   value = a - b;
      exe_pkg::OP_AND:   value = a & b;
      exe_pkg::OP_OR:    value = a | b;
      exe_pkg::OP_XOR:   value = a ^ b;
      exe_pkg::OP_SLL:   value = a << b[4:0];
      exe_pkg::OP_SRL:   value = a >> b[4:0];
      exe_pkg::OP_SLT:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exe_pkg::OP_MUL:   value = product[31:0];
      exe_pkg::OP_MULHU: value = product[63:32];
      exe_pkg::OP_DIVU:  value = (b == 32'd0) ? 32'hffff_ffff : a / b;
      exe_pkg::OP_REMU:  value = (b == 32'd0) ? a : a % b;
      default:           value = 32'hx;
    endcase
    return value;
  endfunction

  task automatic build_table();
    logic [31:0] draw;
    logic [4:0]  code;
    // Random operands in r1..r5 and a small divisor in r6
    for (int r = 1; r <= 5; r++) begin
      add_row(exe_pkg::OP_ADD, 5'(r), 5'd0, 5'd0, $random(seed), 1'b1);
    end
    add_row(exe_pkg::OP_ADD, 5'd6, 5'd0, 5'd0, 32'd7, 1'b1);
    add_row(exe_pkg::OP_ADD, 5'd7, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_SUB, 5'd8, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_AND, 5'd9, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_OR, 5'd10, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_XOR, 5'd11, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_SLL, 5'd12, 5'd1, 5'd3, 32'd0, 1'b0);
    add_row(exe_pkg::OP_SRL, 5'd13, 5'd1, 5'd3, 32'd0, 1'b0);
    add_row(exe_pkg::OP_SLT, 5'd14, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_SLT, 5'd15, 5'd2, 5'd1, 32'd0, 1'b0);
    // Dependency chain through the iterative units
    add_row(exe_pkg::OP_MUL, 5'd16, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_MULHU, 5'd17, 5'd16, 5'd3, 32'd0, 1'b0);
    add_row(exe_pkg::OP_DIVU, 5'd18, 5'd17, 5'd6, 32'd0, 1'b0);
    add_row(exe_pkg::OP_REMU, 5'd19, 5'd17, 5'd6, 32'd0, 1'b0);
    add_row(exe_pkg::OP_ADD, 5'd20, 5'd19, 5'd18, 32'd0, 1'b0);
    add_row(exe_pkg::OP_MUL, 5'd21, 5'd20, 5'd20, 32'd0, 1'b0);
    add_row(exe_pkg::OP_SUB, 5'd22, 5'd21, 5'd1, 32'd0, 1'b0);
    // Divide by zero directly and through a register holding zero
    add_row(exe_pkg::OP_DIVU, 5'd23, 5'd1, 5'd0, 32'd0, 1'b0);
    add_row(exe_pkg::OP_REMU, 5'd24, 5'd2, 5'd0, 32'd0, 1'b0);
    add_row(exe_pkg::OP_ADD, 5'd25, 5'd0, 5'd0, 32'd0, 1'b1);
    add_row(exe_pkg::OP_DIVU, 5'd26, 5'd3, 5'd25, 32'd0, 1'b0);
    add_row(exe_pkg::OP_REMU, 5'd27, 5'd4, 5'd25, 32'd0, 1'b0);
    // One long divide with more dependents than station slots
    add_row(exe_pkg::OP_DIVU, 5'd28, 5'd1, 5'd6, 32'd0, 1'b0);
    for (int k = 0; k < RS_ENTRIES + 4; k++) begin
      add_row(exe_pkg::OP_XOR, 5'(29 + k % 3), 5'd28, 5'd0, $random(seed), 1'b1);
    end
    // Writes to r0 must stay invisible
    add_row(exe_pkg::OP_ADD, 5'd0, 5'd1, 5'd0, 32'd5, 1'b1);
    add_row(exe_pkg::OP_OR, 5'd30, 5'd0, 5'd0, 32'd0, 1'b0);
    add_row(exe_pkg::OP_MUL, 5'd0, 5'd1, 5'd2, 32'd0, 1'b0);
    add_row(exe_pkg::OP_ADD, 5'd31, 5'd0, 5'd0, 32'd9, 1'b1);
    add_row(exe_pkg::OP_SUB, 5'd30, 5'd31, 5'd0, 32'd0, 1'b0);
    // Random mix of opcodes, registers and immediates
    for (int k = 0; k < 12; k++) begin
      draw = $random(seed);
      code = draw[3] ? {3'b110, draw[1:0]} : {2'b00, draw[2:0]};
      add_row(exe_pkg::opcode_e'(code), draw[8:4], draw[13:9], draw[18:14],
              $random(seed), draw[19]);
    end
  endtask

  initial begin
    logic [31:0]            op_a;
    logic [31:0]            op_b;
    exe_pkg::dispatch_req_t row;
    int                     drain;
    clk            = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_req   = '0;
    seed           = 32'hd9bf_6adb;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    for (int i = 0; i < MAX_ROWS; i++) begin
      wb_seen[i] = 1'b0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < num_rows; i++) begin
      row = table_rows[i];
      dispatch_valid <= 1'b1;
      dispatch_req   <= row;
      @(posedge clk);
      while (dispatch_stall) begin
        stall_seen = 1'b1;
        @(posedge clk);
      end
      // Accepted on this edge
      if (dispatch_robid !== 7'(i)) begin
        $display("Mismatch at %0t: dispatch_robid got %0d expected %0d",
                 $time, dispatch_robid, i);
        mismatches++;
      end
      op_a = model_regs[row.rs1];
      op_b = row.use_imm ? row.imm : model_regs[row.rs2];
      exp_result[i] = expected_value(row.op, op_a, op_b);
      exp_rd[i]     = row.rd;
      if (row.rd != 5'd0) begin
        model_regs[row.rd] = exp_result[i];
      end
    end
    dispatch_valid <= 1'b0;
    // Outstanding writebacks, bounded so lost tags end up counted
    drain = 0;
    while (wb_count < num_rows && drain < 20 * num_rows) begin
      @(posedge clk);
      drain++;
    end
    // Extra cycles to catch late duplicates
    repeat (40) @(posedge clk);
    for (int i = 0; i < num_rows; i++) begin
      if (!wb_seen[i]) begin
        $display("Error: no writeback arrived for tag %0d", i);
        missing++;
      end
    end
    if (!stall_seen) begin
      $display("Error: dispatch_stall never rose while dependents filled the station");
      other_errors++;
    end
    $display("Error counts: mismatches %0d, duplicates %0d, missing %0d, other %0d",
             mismatches, duplicates, missing, other_errors);
    if (mismatches + duplicates + missing + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Writeback monitor sampling at the rising edge
  always @(posedge clk) begin
    if (reset) begin
      if (reset_edges > 0 && (wb_valid !== 1'b0 || dispatch_stall !== 1'b0)) begin
        $display("Error at %0t: wb_valid or dispatch_stall not low during reset", $time);
        other_errors++;
      end
      reset_edges++;
    end else begin
      if (accepted_count == 0 && dispatch_stall !== 1'b0) begin
        $display("Error at %0t: dispatch_stall high before the first dispatch", $time);
        other_errors++;
      end
      if (wb_valid) begin
        if (wb.robid >= accepted_count) begin
          $display("Error at %0t: writeback for tag %0d, which was never dispatched",
                   $time, wb.robid);
          other_errors++;
        end else if (wb_seen[wb.robid]) begin
          $display("Error at %0t: tag %0d written back twice", $time, wb.robid);
          duplicates++;
        end else begin
          wb_seen[wb.robid] = 1'b1;
          wb_count++;
          if (wb.result !== exp_result[wb.robid]) begin
            $display("Mismatch at %0t: wb.result for tag %0d got %h expected %h",
                     $time, wb.robid, wb.result, exp_result[wb.robid]);
            mismatches++;
          end
          if (wb.rd !== exp_rd[wb.robid]) begin
            $display("Mismatch at %0t: wb.rd for tag %0d got %0d expected %0d",
                     $time, wb.robid, wb.rd, exp_rd[wb.robid]);
            mismatches++;
          end
        end
      end
      if (dispatch_valid && !dispatch_stall) begin
        accepted_count++;
      end
    end
  end

  initial begin
    wait (table_ready);
    #((40 * num_rows + 10) * 100);
    $display("Timeout: only %0d of %0d writebacks arrived", wb_count, num_rows);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== source/exe_core.sv ====
// Integer back end top: decode, reservation station, two ALUs, two iterative units, arbiter
`timescale 1ns/1ns
module exe_core #(
  parameter int RS_ENTRIES = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dispatch_valid,
  input  exe_pkg::dispatch_req_t dispatch_req,
  output logic                   dispatch_stall,
  output logic [6:0]             dispatch_robid,
  output logic                   wb_valid,
  output exe_pkg::wb_t           wb
);

  logic               rs_write;
  exe_pkg::rs_entry_t rs_entry;
  exe_pkg::fu_req_t   issue_req;
  logic               sc0_issue, sc1_issue, mc0_issue, mc1_issue;
  logic               sc0_busy, sc1_busy, mc0_busy, mc1_busy;
  logic               sc0_done, sc1_done, mc0_done, mc1_done;
  logic               sc0_grant, sc1_grant, mc0_grant, mc1_grant;
  exe_pkg::wb_t       sc0_result, sc1_result, mc0_result, mc1_result;

  // Station full level doubles as the dispatch stall
  dispatch_decode u_decode (
    .clk(clk), .reset(reset), .dispatch_valid(dispatch_valid), .dispatch_req(dispatch_req),
    .rs_full(dispatch_stall), .wb_valid(wb_valid), .wb(wb),
    .dispatch_robid(dispatch_robid), .rs_write(rs_write), .rs_entry(rs_entry)
  );

  res_station #(.RS_ENTRIES(RS_ENTRIES)) u_res_station (
    .clk(clk), .reset(reset), .rs_write(rs_write), .rs_entry(rs_entry),
    .rs_full(dispatch_stall), .wb_valid(wb_valid), .wb(wb),
    .sc0_busy(sc0_busy), .sc1_busy(sc1_busy), .mc0_busy(mc0_busy), .mc1_busy(mc1_busy),
    .sc0_issue(sc0_issue), .sc1_issue(sc1_issue), .mc0_issue(mc0_issue),
    .mc1_issue(mc1_issue), .issue_req(issue_req)
  );

  sc_alu u_sc0 (.clk(clk), .reset(reset), .issue(sc0_issue), .req(issue_req), .grant(sc0_grant),
                .busy(sc0_busy), .done(sc0_done), .result(sc0_result));
  sc_alu u_sc1 (.clk(clk), .reset(reset), .issue(sc1_issue), .req(issue_req), .grant(sc1_grant),
                .busy(sc1_busy), .done(sc1_done), .result(sc1_result));
  mc_unit u_mc0 (.clk(clk), .reset(reset), .issue(mc0_issue), .req(issue_req), .grant(mc0_grant),
                 .busy(mc0_busy), .done(mc0_done), .result(mc0_result));
  mc_unit u_mc1 (.clk(clk), .reset(reset), .issue(mc1_issue), .req(issue_req), .grant(mc1_grant),
                 .busy(mc1_busy), .done(mc1_done), .result(mc1_result));

  result_arbiter u_arbiter (
    .mc0_done(mc0_done), .mc1_done(mc1_done), .sc0_done(sc0_done), .sc1_done(sc1_done),
    .mc0_result(mc0_result), .mc1_result(mc1_result),
    .sc0_result(sc0_result), .sc1_result(sc1_result),
    .mc0_grant(mc0_grant), .mc1_grant(mc1_grant), .sc0_grant(sc0_grant), .sc1_grant(sc1_grant),
    .wb_valid(wb_valid), .wb(wb)
  );

endmodule

// ==== source/result_arbiter.sv ====
// Fixed-priority writeback arbiter driving the common result bus
`timescale 1ns/1ns
module result_arbiter (
  input  logic         mc0_done,
  input  logic         mc1_done,
  input  logic         sc0_done,
  input  logic         sc1_done,
  input  exe_pkg::wb_t mc0_result,
  input  exe_pkg::wb_t mc1_result,
  input  exe_pkg::wb_t sc0_result,
  input  exe_pkg::wb_t sc1_result,
  output logic         mc0_grant,
  output logic         mc1_grant,
  output logic         sc0_grant,
  output logic         sc1_grant,
  output logic         wb_valid,
  output exe_pkg::wb_t wb
);

  // Long operations first so short streams cannot starve them
  assign mc0_grant = mc0_done;
  assign mc1_grant = mc1_done && !mc0_done;
  assign sc0_grant = sc0_done && !mc0_done && !mc1_done;
  assign sc1_grant = sc1_done && !mc0_done && !mc1_done && !sc0_done;

  assign wb_valid = mc0_done || mc1_done || sc0_done || sc1_done;

  always_comb begin
    if (mc0_grant) begin
      wb = mc0_result;
    end else if (mc1_grant) begin
      wb = mc1_result;
    end else if (sc0_grant) begin
      wb = sc0_result;
    end else begin
      // Also the idle value, qualified by wb_valid
      wb = sc1_result;
    end
  end

endmodule

// ==== source/mc_unit.sv ====
// Iterative unit: 32-step shift-add multiplier and restoring divider
`timescale 1ns/1ns
module mc_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             issue,
  input  exe_pkg::fu_req_t req,
  input  logic             grant,
  output logic             busy,
  output logic             done,
  output exe_pkg::wb_t     result
);

  typedef enum logic [1:0] {IDLE, RUN, HOLD} state_e;

  state_e           state;
  logic [4:0]       count;
  exe_pkg::opcode_e op_q;
  logic [6:0]       robid_q;
  logic [4:0]       rd_q;
  logic [31:0]      b_q;
  logic [63:0]      acc;
  logic             is_mul;
  logic [32:0]      add_sum;
  logic [32:0]      rem_shift;
  logic [32:0]      trial;

  assign is_mul = op_q == exe_pkg::OP_MUL || op_q == exe_pkg::OP_MULHU;

  // Multiply step: add multiplicand into the high half, then shift right
  assign add_sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, b_q} : 33'd0);

  // Divide step: acc is {remainder, quotient}, shift left and trial subtract.
  // A zero divisor always succeeds, giving all ones and the dividend back
  assign rem_shift = acc[63:31];
  assign trial     = rem_shift - {1'b0, b_q};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (issue) begin
            op_q    <= req.op;
            robid_q <= req.robid;
            rd_q    <= req.rd;
            b_q     <= req.op2;
            count   <= '0;
            if (exe_pkg::is_single_cycle(req.op)) begin
              acc   <= {32'b0, exe_pkg::alu_result(req.op, req.op1, req.op2)};
              state <= HOLD;
            end else begin
              acc   <= {32'b0, req.op1};
              state <= RUN;
            end
          end
        end
        RUN: begin
          if (is_mul) begin
            acc <= {add_sum, acc[31:1]};
          end else if (!trial[32]) begin
            acc <= {trial[31:0], acc[30:0], 1'b1};
          end else begin
            acc <= {rem_shift[31:0], acc[30:0], 1'b0};
          end
          count <= count + 5'd1;
          if (count == 5'd31) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (grant) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy = state != IDLE;
  assign done = state == HOLD;

  // High half carries MULHU product and REMU remainder
  assign result.robid  = robid_q;
  assign result.rd     = rd_q;
  assign result.result = (op_q == exe_pkg::OP_MULHU || op_q == exe_pkg::OP_REMU) ?
                         acc[63:32] : acc[31:0];

endmodule

// ==== source/sc_alu.sv ====
// Single-cycle ALU with a result register held until the arbiter grants it
`timescale 1ns/1ns
module sc_alu (
  input  logic             clk,
  input  logic             reset,
  input  logic             issue,
  input  exe_pkg::fu_req_t req,
  input  logic             grant,
  output logic             busy,
  output logic             done,
  output exe_pkg::wb_t     result
);

  logic         done_q;
  exe_pkg::wb_t result_q;

  // Done flag clears on grant
  always_ff @(posedge clk) begin
    if (reset) begin
      done_q <= 1'b0;
    end else if (issue) begin
      done_q <= 1'b1;
    end else if (grant) begin
      done_q <= 1'b0;
    end
  end

  // Result payload, captured on the issue edge
  always_ff @(posedge clk) begin
    if (issue) begin
      result_q.robid  <= req.robid;
      result_q.rd     <= req.rd;
      result_q.result <= exe_pkg::alu_result(req.op, req.op1, req.op2);
    end
  end

  // Busy while a result waits for the bus
  assign busy   = done_q;
  assign done   = done_q;
  assign result = result_q;

endmodule

// ==== source/res_station.sv ====
// Reservation station: insert, tag wakeup, oldest-slot ready select and unit steering
`timescale 1ns/1ns
module res_station #(
  parameter int RS_ENTRIES = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               rs_write,
  input  exe_pkg::rs_entry_t rs_entry,
  output logic               rs_full,
  input  logic               wb_valid,
  input  exe_pkg::wb_t       wb,
  input  logic               sc0_busy,
  input  logic               sc1_busy,
  input  logic               mc0_busy,
  input  logic               mc1_busy,
  output logic               sc0_issue,
  output logic               sc1_issue,
  output logic               mc0_issue,
  output logic               mc1_issue,
  output exe_pkg::fu_req_t   issue_req
);

  localparam int IDX_W = $clog2(RS_ENTRIES);

  exe_pkg::rs_entry_t    slot [RS_ENTRIES];
  logic [RS_ENTRIES-1:0] slot_valid;
  logic [RS_ENTRIES-1:0] slot_ready;
  logic [IDX_W:0]        insert_pick;
  logic [IDX_W:0]        issue_pick;
  logic [IDX_W-1:0]      insert_idx;
  logic [IDX_W-1:0]      issue_idx;
  logic                  issue_found;
  logic                  sel_sc;
  logic                  any_issue;

  // {found, index} of the lowest set bit
  function automatic logic [IDX_W:0] lowest_set(input logic [RS_ENTRIES-1:0] vec);
    logic [IDX_W:0] pick;
    pick = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (vec[i]) begin
        pick = {1'b1, IDX_W'(i)};
      end
    end
    return pick;
  endfunction

  always_comb begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      slot_ready[i] = slot_valid[i] && slot[i].op1ready && slot[i].op2ready;
    end
    insert_pick = lowest_set(~slot_valid);
    insert_idx  = insert_pick[IDX_W-1:0];
    rs_full     = ~insert_pick[IDX_W];
    issue_pick  = lowest_set(slot_ready);
    issue_idx   = issue_pick[IDX_W-1:0];
    issue_found = issue_pick[IDX_W];
  end

  always_comb begin
    issue_req.op    = slot[issue_idx].op;
    issue_req.robid = slot[issue_idx].robid;
    issue_req.rd    = slot[issue_idx].rd;
    issue_req.op1   = slot[issue_idx].op1;
    issue_req.op2   = slot[issue_idx].op2;
    sel_sc = exe_pkg::is_single_cycle(slot[issue_idx].op);
    // First free unit in order sc0, sc1, mc0, mc1
    sc0_issue = issue_found && sel_sc && !sc0_busy;
    sc1_issue = issue_found && sel_sc && !sc1_busy && !sc0_issue;
    mc0_issue = issue_found && !mc0_busy && !sc0_issue && !sc1_issue;
    mc1_issue = issue_found && !mc1_busy && !sc0_issue && !sc1_issue && !mc0_issue;
    any_issue = sc0_issue || sc1_issue || mc0_issue || mc1_issue;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_valid <= '0;
    end else begin
      if (any_issue) begin
        slot_valid[issue_idx] <= 1'b0;
      end
      for (int i = 0; i < RS_ENTRIES; i++) begin
        if (wb_valid && slot_valid[i] && !slot[i].op1ready && slot[i].op1[6:0] == wb.robid) begin
          slot[i].op1ready <= 1'b1;
          slot[i].op1      <= wb.result;
        end
        if (wb_valid && slot_valid[i] && !slot[i].op2ready && slot[i].op2[6:0] == wb.robid) begin
          slot[i].op2ready <= 1'b1;
          slot[i].op2      <= wb.result;
        end
      end
      // Insert target is free, so it never collides with wakeup or issue
      if (rs_write && !rs_full) begin
        slot_valid[insert_idx] <= 1'b1;
        slot[insert_idx]       <= rs_entry;
      end
    end
  end

endmodule

// ==== source/dispatch_decode.sv ====
// Decode stage: register file, register status table, tag counter and writeback bypass
`timescale 1ns/1ns
module dispatch_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  exe_pkg::dispatch_req_t dispatch_req,
  input  logic                  rs_full,
  input  logic                  wb_valid,
  input  exe_pkg::wb_t          wb,
  output logic [6:0]            dispatch_robid,
  output logic                  rs_write,
  output exe_pkg::rs_entry_t    rs_entry
);

  logic [31:0] reg_file [32];
  logic [31:0] reg_busy;
  logic [6:0]  reg_tag [32];
  logic [6:0]  next_robid;
  logic        accept;
  logic        wb_owner;
  logic [32:0] src1;
  logic [32:0] src2;

  // Returns {ready, value-or-tag} for one source register
  function automatic logic [32:0] read_src(input logic [4:0] src);
    logic [32:0] out;
    if (src == 5'd0) begin
      out = {1'b1, 32'b0};
    end else if (!reg_busy[src]) begin
      out = {1'b1, reg_file[src]};
    end else if (wb_valid && wb.robid == reg_tag[src]) begin
      // Producer finishing this very cycle
      out = {1'b1, wb.result};
    end else begin
      out = {1'b0, 25'b0, reg_tag[src]};
    end
    return out;
  endfunction

  assign accept = dispatch_valid && !rs_full;
  assign rs_write = accept;
  assign dispatch_robid = next_robid;

  // Only the youngest producer of a register may update it
  assign wb_owner = wb_valid && wb.rd != 5'd0 && reg_busy[wb.rd] && reg_tag[wb.rd] == wb.robid;

  always_comb begin
    src1 = read_src(dispatch_req.rs1);
    src2 = read_src(dispatch_req.rs2);
    rs_entry.op       = dispatch_req.op;
    rs_entry.robid    = next_robid;
    rs_entry.rd       = dispatch_req.rd;
    rs_entry.op1ready = src1[32];
    rs_entry.op1      = src1[31:0];
    rs_entry.op2ready = dispatch_req.use_imm ? 1'b1 : src2[32];
    rs_entry.op2      = dispatch_req.use_imm ? dispatch_req.imm : src2[31:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      next_robid <= '0;
      reg_busy   <= '0;
      for (int i = 0; i < 32; i++) begin
        reg_file[i] <= '0;
      end
    end else begin
      if (wb_owner) begin
        reg_file[wb.rd] <= wb.result;
        reg_busy[wb.rd] <= 1'b0;
      end
      // Later in the block, so a same-rd dispatch beats the clear
      if (accept) begin
        next_robid <= next_robid + 7'd1;
        if (dispatch_req.rd != 5'd0) begin
          reg_busy[dispatch_req.rd] <= 1'b1;
          reg_tag[dispatch_req.rd]  <= next_robid;
        end
      end
    end
  end

endmodule

// ==== source/exe_pkg.sv ====
// Shared opcode enum, unit-class rule, single-cycle ALU function and bus structs
package exe_pkg;

  // Top two bits 11 select the multi-cycle unit class
  typedef enum logic [4:0] {
    OP_ADD   = 5'h00,
    OP_SUB   = 5'h01,
    OP_AND   = 5'h02,
    OP_OR    = 5'h03,
    OP_XOR   = 5'h04,
    OP_SLL   = 5'h05,
    OP_SRL   = 5'h06,
    OP_SLT   = 5'h07,
    OP_MUL   = 5'h18,
    OP_MULHU = 5'h19,
    OP_DIVU  = 5'h1a,
    OP_REMU  = 5'h1b
  } opcode_e;

  typedef struct packed {
    opcode_e     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        use_imm;
  } dispatch_req_t;

  // Operand not ready: low 7 bits carry the producer tag
  typedef struct packed {
    opcode_e     op;
    logic [6:0]  robid;
    logic [4:0]  rd;
    logic        op1ready;
    logic [31:0] op1;
    logic        op2ready;
    logic [31:0] op2;
  } rs_entry_t;

  typedef struct packed {
    opcode_e     op;
    logic [6:0]  robid;
    logic [4:0]  rd;
    logic [31:0] op1;
    logic [31:0] op2;
  } fu_req_t;

  typedef struct packed {
    logic [6:0]  robid;
    logic [4:0]  rd;
    logic [31:0] result;
  } wb_t;

  function automatic logic is_single_cycle(input opcode_e op);
    logic [4:0] code;
    code = op;
    return ~&code[4:3];
  endfunction

  // Shared by both unit types for the one-cycle opcodes
  function automatic logic [31:0] alu_result(input opcode_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] value;
    case (op)
      OP_ADD:  value = a + b;
      OP_SUB:  value = a - b;
      OP_AND:  value = a & b;
      OP_OR:   value = a | b;
      OP_XOR:  value = a ^ b;
      OP_SLL:  value = a << b[4:0];
      OP_SRL:  value = a >> b[4:0];
      OP_SLT:  value = {31'b0, $signed(a) < $signed(b)};
      default: value = '0;
    endcase
    return value;
  endfunction

endpackage
